// File: Makefile
VERILATOR ?= verilator
TOP       ?= adam_periph_tb
FILELIST  ?= adam_periph_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG) || ! grep -q "Test OK" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: adam_periph_top.f
+incdir+hdl
hdl/adam_periph_pkg.sv
hdl/adam_reg_if.sv
hdl/adam_periph_ctrl.sv
hdl/adam_gpio_bank.sv
hdl/adam_pin_mux.sv
hdl/adam_pwm_timer.sv
hdl/adam_periph_top.sv
verification/adam_periph_checker.sv
verification/adam_periph_tb.sv

// File: hdl/adam_gpio_bank.sv
`default_nettype none

`include "adam_periph_defines.svh"

module adam_gpio_bank (
    input  logic                        clk,
    input  logic                        rst_i,

    input  logic [`ADAM_GPIO_WIDTH-1:0] pad_in_i,
    output logic [`ADAM_GPIO_WIDTH-1:0] gpio_o_o,
    output logic [`ADAM_GPIO_WIDTH-1:0] gpio_mode_o,
    output logic [`ADAM_GPIO_WIDTH-1:0] gpio_otype_o,

    adam_reg_if.block                   regs
);

    logic [`ADAM_GPIO_WIDTH-1:0] out_q;
    logic [`ADAM_GPIO_WIDTH-1:0] mode_q;
    logic [`ADAM_GPIO_WIDTH-1:0] otype_q;
    logic [`ADAM_GPIO_WIDTH-1:0] in_meta_q;
    logic [`ADAM_GPIO_WIDTH-1:0] in_sync_q;
    logic                        ofs_known;
    logic                        ofs_ro;

    always_comb begin
        regs.rdata = '0;
        ofs_known  = 1'b1;
        ofs_ro     = 1'b0;
        case (regs.ofs)
            `GPIO_OUT:   regs.rdata = adam_periph_pkg::data_t'(out_q);
            `GPIO_MODE:  regs.rdata = adam_periph_pkg::data_t'(mode_q);
            `GPIO_OTYPE: regs.rdata = adam_periph_pkg::data_t'(otype_q);
            `GPIO_IN: begin
                regs.rdata = adam_periph_pkg::data_t'(in_sync_q);
                ofs_ro     = 1'b1;
            end
            default:     ofs_known = 1'b0;
        endcase
    end

    assign regs.err = (regs.wr && (!ofs_known || ofs_ro)) || (regs.rd && !ofs_known);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            out_q   <= '0;
            mode_q  <= '0;
            otype_q <= '0;
        end else if (regs.wr && !regs.err) begin
            case (regs.ofs)
                `GPIO_OUT:   out_q   <= regs.wdata[`ADAM_GPIO_WIDTH-1:0];
                `GPIO_MODE:  mode_q  <= regs.wdata[`ADAM_GPIO_WIDTH-1:0];
                `GPIO_OTYPE: otype_q <= regs.wdata[`ADAM_GPIO_WIDTH-1:0];
                default: ;
            endcase
        end
    end

    // Two-flop synchronizer for the pad inputs
    always_ff @(posedge clk) begin
        if (rst_i) begin
            in_meta_q <= '0;
            in_sync_q <= '0;
        end else begin
            in_meta_q <= pad_in_i;
            in_sync_q <= in_meta_q;
        end
    end

    assign gpio_o_o     = out_q;
    assign gpio_mode_o  = mode_q;
    assign gpio_otype_o = otype_q;

endmodule

`default_nettype wire

// File: hdl/adam_periph_ctrl.sv
`default_nettype none

`include "adam_periph_defines.svh"

module adam_periph_ctrl (
    input  logic                    clk,
    input  logic                    rst_i,

    input  logic                    psel_i,
    input  logic                    penable_i,
    input  logic                    pwrite_i,
    input  adam_periph_pkg::paddr_t paddr_i,
    input  adam_periph_pkg::data_t  pwdata_i,
    output logic                    pready_o,
    output adam_periph_pkg::data_t  prdata_o,
    output logic                    pslverr_o,

    input  logic                    pause_req_i,
    output logic                    pause_ack_o,
    output logic                    paused_o,

    adam_reg_if.ctrl                gpio_if,
    adam_reg_if.ctrl                mux_if,
    adam_reg_if.ctrl                tmr_if
);

    logic                       access;
    logic                       rd_req;
    logic                       wr_req;
    logic [`ADAM_REG_OFS_W-1:0] ofs;
    adam_periph_pkg::blk_sel_t  blk;
    adam_periph_pkg::data_t     blk_rdata;
    logic                       blk_err;
    logic                       pause_ack_q;

    assign access = psel_i && penable_i;
    assign blk    = adam_periph_pkg::blk_sel_t'(paddr_i[9:8]);
    assign ofs    = paddr_i[`ADAM_REG_OFS_W-1:0];
    assign rd_req = access && !pwrite_i;
    // Writes are dropped while paused
    assign wr_req = access && pwrite_i && !pause_ack_q;

    assign gpio_if.wr    = wr_req && (blk == adam_periph_pkg::BLK_GPIO);
    assign gpio_if.rd    = rd_req && (blk == adam_periph_pkg::BLK_GPIO);
    assign gpio_if.ofs   = ofs;
    assign gpio_if.wdata = pwdata_i;

    assign mux_if.wr     = wr_req && (blk == adam_periph_pkg::BLK_MUX);
    assign mux_if.rd     = rd_req && (blk == adam_periph_pkg::BLK_MUX);
    assign mux_if.ofs    = ofs;
    assign mux_if.wdata  = pwdata_i;

    assign tmr_if.wr     = wr_req && (blk == adam_periph_pkg::BLK_TIMER);
    assign tmr_if.rd     = rd_req && (blk == adam_periph_pkg::BLK_TIMER);
    assign tmr_if.ofs    = ofs;
    assign tmr_if.wdata  = pwdata_i;

    always_comb begin
        blk_rdata = '0;
        blk_err   = 1'b0;
        case (blk)
            adam_periph_pkg::BLK_GPIO: begin
                blk_rdata = gpio_if.rdata;
                blk_err   = gpio_if.err;
            end
            adam_periph_pkg::BLK_MUX: begin
                blk_rdata = mux_if.rdata;
                blk_err   = mux_if.err;
            end
            adam_periph_pkg::BLK_TIMER: begin
                blk_rdata = tmr_if.rdata;
                blk_err   = tmr_if.err;
            end
            adam_periph_pkg::BLK_NONE: blk_err = 1'b1;
        endcase
    end

    // Zero wait states
    assign pready_o  = access;
    assign pslverr_o = access && (blk_err || (pwrite_i && pause_ack_q));
    assign prdata_o  = rd_req ? blk_rdata : '0;

    // Grant pause only between transfers
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pause_ack_q <= 1'b0;
        end else if (!pause_req_i) begin
            pause_ack_q <= 1'b0;
        end else if (!psel_i) begin
            pause_ack_q <= 1'b1;
        end
    end

    assign pause_ack_o = pause_ack_q;
    assign paused_o    = pause_ack_q;

endmodule

`default_nettype wire

// File: hdl/adam_periph_defines.svh
`ifndef ADAM_PERIPH_DEFINES_SVH
`define ADAM_PERIPH_DEFINES_SVH

// Bus and pad sizes
`define ADAM_DATA_W     32
`define ADAM_PADDR_W    12
`define ADAM_GPIO_WIDTH 16
`define ADAM_REG_OFS_W  6

// GPIO bank register offsets
`define GPIO_OUT    6'h00
`define GPIO_MODE   6'h04
`define GPIO_OTYPE  6'h08
`define GPIO_IN     6'h0C

// Pin mux function register
`define MUX_FUNC    6'h00

// PWM timer register offsets
`define TMR_CTRL    6'h00
`define TMR_PERIOD  6'h04
`define TMR_COMPARE 6'h08
`define TMR_COUNT   6'h0C

`endif

// File: hdl/adam_periph_pkg.sv
`default_nettype none

`include "adam_periph_defines.svh"

package adam_periph_pkg;

    typedef logic [`ADAM_DATA_W-1:0]  data_t;
    typedef logic [`ADAM_PADDR_W-1:0] paddr_t;

    // Pin function where OFF2 acts as OFF
    typedef enum logic [1:0] {
        FUNC_GPIO = 2'd0,
        FUNC_PWM  = 2'd1,
        FUNC_OFF  = 2'd2,
        FUNC_OFF2 = 2'd3
    } func_t;

    // Block select from paddr[9:8]
    typedef enum logic [1:0] {
        BLK_GPIO  = 2'd0,
        BLK_MUX   = 2'd1,
        BLK_TIMER = 2'd2,
        BLK_NONE  = 2'd3
    } blk_sel_t;

endpackage

`default_nettype wire

// File: hdl/adam_periph_top.sv
`default_nettype none

`include "adam_periph_defines.svh"

module adam_periph_top (
    input  logic                          clk,
    input  logic                          rst_i,

    input  logic                          psel_i,
    input  logic                          penable_i,
    input  logic                          pwrite_i,
    input  adam_periph_pkg::paddr_t       paddr_i,
    input  adam_periph_pkg::data_t        pwdata_i,
    output logic                          pready_o,
    output adam_periph_pkg::data_t        prdata_o,
    output logic                          pslverr_o,

    input  logic                          pause_req_i,
    output logic                          pause_ack_o,

    input  logic [`ADAM_GPIO_WIDTH-1:0]   pad_i_i,
    output logic [`ADAM_GPIO_WIDTH-1:0]   pad_o_o,
    output logic [`ADAM_GPIO_WIDTH-1:0]   pad_mode_o_o,
    output logic [`ADAM_GPIO_WIDTH-1:0]   pad_otype_o_o,
    output logic [2*`ADAM_GPIO_WIDTH-1:0] pin_func_o
);

    logic [`ADAM_GPIO_WIDTH-1:0] gpio_o;
    logic [`ADAM_GPIO_WIDTH-1:0] gpio_mode;
    logic [`ADAM_GPIO_WIDTH-1:0] gpio_otype;
    logic                        pwm;
    logic                        paused;

    adam_reg_if gpio_if ();
    adam_reg_if mux_if ();
    adam_reg_if tmr_if ();

    adam_periph_ctrl u_adam_periph_ctrl (
        .clk         (clk),
        .rst_i       (rst_i),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .paddr_i     (paddr_i),
        .pwdata_i    (pwdata_i),
        .pready_o    (pready_o),
        .prdata_o    (prdata_o),
        .pslverr_o   (pslverr_o),
        .pause_req_i (pause_req_i),
        .pause_ack_o (pause_ack_o),
        .paused_o    (paused),
        .gpio_if     (gpio_if.ctrl),
        .mux_if      (mux_if.ctrl),
        .tmr_if      (tmr_if.ctrl)
    );

    adam_gpio_bank u_adam_gpio_bank (
        .clk          (clk),
        .rst_i        (rst_i),
        .pad_in_i     (pad_i_i),
        .gpio_o_o     (gpio_o),
        .gpio_mode_o  (gpio_mode),
        .gpio_otype_o (gpio_otype),
        .regs         (gpio_if.block)
    );

    adam_pin_mux u_adam_pin_mux (
        .clk           (clk),
        .rst_i         (rst_i),
        .gpio_o_i      (gpio_o),
        .gpio_mode_i   (gpio_mode),
        .gpio_otype_i  (gpio_otype),
        .pwm_i         (pwm),
        .pad_o_o       (pad_o_o),
        .pad_mode_o_o  (pad_mode_o_o),
        .pad_otype_o_o (pad_otype_o_o),
        .pin_func_o    (pin_func_o),
        .regs          (mux_if.block)
    );

    adam_pwm_timer u_adam_pwm_timer (
        .clk      (clk),
        .rst_i    (rst_i),
        .paused_i (paused),
        .pwm_o    (pwm),
        .regs     (tmr_if.block)
    );

endmodule

`default_nettype wire

// File: hdl/adam_pin_mux.sv
`default_nettype none

`include "adam_periph_defines.svh"

module adam_pin_mux (
    input  logic                          clk,
    input  logic                          rst_i,

    input  logic [`ADAM_GPIO_WIDTH-1:0]   gpio_o_i,
    input  logic [`ADAM_GPIO_WIDTH-1:0]   gpio_mode_i,
    input  logic [`ADAM_GPIO_WIDTH-1:0]   gpio_otype_i,
    input  logic                          pwm_i,

    output logic [`ADAM_GPIO_WIDTH-1:0]   pad_o_o,
    output logic [`ADAM_GPIO_WIDTH-1:0]   pad_mode_o_o,
    output logic [`ADAM_GPIO_WIDTH-1:0]   pad_otype_o_o,
    output logic [2*`ADAM_GPIO_WIDTH-1:0] pin_func_o,

    adam_reg_if.block                     regs
);

    logic [2*`ADAM_GPIO_WIDTH-1:0] func_q;
    logic                          ofs_known;

    assign ofs_known  = (regs.ofs == `MUX_FUNC);
    assign regs.rdata = ofs_known ? adam_periph_pkg::data_t'(func_q) : '0;
    assign regs.err   = (regs.wr || regs.rd) && !ofs_known;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            func_q <= '0;
        end else if (regs.wr && !regs.err) begin
            func_q <= regs.wdata[2*`ADAM_GPIO_WIDTH-1:0];
        end
    end

    assign pin_func_o = func_q;

    for (genvar i = 0; i < `ADAM_GPIO_WIDTH; i++) begin : g_pin
        always_comb begin
            case (adam_periph_pkg::func_t'(func_q[2*i +: 2]))
                adam_periph_pkg::FUNC_GPIO: begin
                    pad_o_o[i]       = gpio_o_i[i];
                    pad_mode_o_o[i]  = gpio_mode_i[i];
                    pad_otype_o_o[i] = gpio_otype_i[i];
                end
                // Timer output drives push-pull
                adam_periph_pkg::FUNC_PWM: begin
                    pad_o_o[i]       = pwm_i;
                    pad_mode_o_o[i]  = 1'b1;
                    pad_otype_o_o[i] = 1'b0;
                end
                adam_periph_pkg::FUNC_OFF, adam_periph_pkg::FUNC_OFF2: begin
                    pad_o_o[i]       = 1'b0;
                    pad_mode_o_o[i]  = 1'b0;
                    pad_otype_o_o[i] = 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/adam_pwm_timer.sv
`default_nettype none

`include "adam_periph_defines.svh"

module adam_pwm_timer (
    input  logic      clk,
    input  logic      rst_i,

    input  logic      paused_i,
    output logic      pwm_o,

    adam_reg_if.block regs
);

    logic        en_q;
    logic [15:0] period_q;
    logic [15:0] compare_q;
    logic [15:0] count_q;
    logic        ofs_known;
    logic        ofs_ro;

    always_comb begin
        regs.rdata = '0;
        ofs_known  = 1'b1;
        ofs_ro     = 1'b0;
        case (regs.ofs)
            `TMR_CTRL:    regs.rdata = adam_periph_pkg::data_t'(en_q);
            `TMR_PERIOD:  regs.rdata = adam_periph_pkg::data_t'(period_q);
            `TMR_COMPARE: regs.rdata = adam_periph_pkg::data_t'(compare_q);
            `TMR_COUNT: begin
                regs.rdata = adam_periph_pkg::data_t'(count_q);
                ofs_ro     = 1'b1;
            end
            default:      ofs_known = 1'b0;
        endcase
    end

    assign regs.err = (regs.wr && (!ofs_known || ofs_ro)) || (regs.rd && !ofs_known);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            en_q      <= 1'b0;
            period_q  <= '0;
            compare_q <= '0;
        end else if (regs.wr && !regs.err) begin
            case (regs.ofs)
                `TMR_CTRL:    en_q      <= regs.wdata[0];
                `TMR_PERIOD:  period_q  <= regs.wdata[15:0];
                `TMR_COMPARE: compare_q <= regs.wdata[15:0];
                default: ;
            endcase
        end
    end

    // Also wraps if PERIOD drops below the running count
    always_ff @(posedge clk) begin
        if (rst_i) begin
            count_q <= '0;
        end else if (en_q && !paused_i) begin
            count_q <= (count_q >= period_q) ? 16'd0 : count_q + 16'd1;
        end
    end

    assign pwm_o = (count_q < compare_q);

endmodule

`default_nettype wire

// File: hdl/adam_reg_if.sv
`default_nettype none

`include "adam_periph_defines.svh"

interface adam_reg_if;

    logic                        wr;
    logic                        rd;
    logic [`ADAM_REG_OFS_W-1:0]  ofs;
    adam_periph_pkg::data_t      wdata;
    adam_periph_pkg::data_t      rdata;
    logic                        err;

    modport ctrl (
        output wr, rd, ofs, wdata,
        input  rdata, err
    );

    // rdata and err are combinational in the block
    modport block (
        input  wr, rd, ofs, wdata,
        output rdata, err
    );

endinterface

`default_nettype wire

// File: verification/adam_periph_checker.sv
`default_nettype none

module adam_periph_checker (
    input logic clk,
    input logic rst_i,
    input logic psel_i,
    input logic penable_i,
    input logic pready_i,
    input logic pslverr_i,
    input logic pause_ack_i,
    input logic wr_req_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // Ready only in an access cycle
    a_ready_in_access: assert property (@(posedge clk) disable iff (rst_i)
        pready_i |-> (psel_i && penable_i))
        else $error("pready_o raised outside an APB access cycle");

    a_err_with_ready: assert property (@(posedge clk) disable iff (rst_i)
        pslverr_i |-> pready_i)
        else $error("pslverr_o raised without pready_o");

    // Register writes are blocked during pause
    a_no_wr_paused: assert property (@(posedge clk) disable iff (rst_i)
        !(wr_req_i && pause_ack_i))
        else $error("register write issued while pause_ack_o is high");

    a_ack_low_after_reset: assert property (@(posedge clk)
        rst_i |=> !pause_ack_i)
        else $error("pause_ack_o high in the cycle after reset");

endmodule

bind adam_periph_ctrl adam_periph_checker u_adam_periph_checker (
    .clk         (clk),
    .rst_i       (rst_i),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pready_i    (pready_o),
    .pslverr_i   (pslverr_o),
    .pause_ack_i (pause_ack_o),
    .wr_req_i    (gpio_if.wr || mux_if.wr || tmr_if.wr)
);

`default_nettype wire

// File: verification/adam_periph_tb.sv
`default_nettype none

`include "adam_periph_defines.svh"

module adam_periph_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam adam_periph_pkg::blk_sel_t GPIO = adam_periph_pkg::BLK_GPIO;
    localparam adam_periph_pkg::blk_sel_t MUX  = adam_periph_pkg::BLK_MUX;
    localparam adam_periph_pkg::blk_sel_t TMR  = adam_periph_pkg::BLK_TIMER;
    localparam adam_periph_pkg::blk_sel_t NONE = adam_periph_pkg::BLK_NONE;

    typedef enum {OP_WR, OP_RD, OP_PADS, OP_SNAP, OP_SAME} op_t;

    typedef struct {
        op_t                     op;
        adam_periph_pkg::paddr_t addr;
        adam_periph_pkg::data_t  wdata;
        logic [15:0]             pad_in;
        logic                    pause;
        adam_periph_pkg::data_t  exp_data;
        logic                    exp_err;
        logic [15:0]             exp_o;
        logic [15:0]             exp_mode;
        logic [15:0]             exp_otype;
        logic [31:0]             exp_func;
    } step_t;

    logic                    clk;
    logic                    rst_i;
    logic                    psel_i;
    logic                    penable_i;
    logic                    pwrite_i;
    adam_periph_pkg::paddr_t paddr_i;
    adam_periph_pkg::data_t  pwdata_i;
    logic                    pready_o;
    adam_periph_pkg::data_t  prdata_o;
    logic                    pslverr_o;
    logic                    pause_req_i;
    logic                    pause_ack_o;
    logic [15:0]             pad_i_i;
    logic [15:0]             pad_o_o;
    logic [15:0]             pad_mode_o_o;
    logic [15:0]             pad_otype_o_o;
    logic [31:0]             pin_func_o;

    step_t                   steps[$];
    logic [15:0]             cur_pad;
    logic                    cur_pause;
    adam_periph_pkg::data_t  snap;
    integer                  seed;
    int                      pass_count;
    int                      fail_count;
    int                      cycles;
    int                      limit;

    adam_periph_top u_adam_periph_top (
        .clk           (clk),
        .rst_i         (rst_i),
        .psel_i        (psel_i),
        .penable_i     (penable_i),
        .pwrite_i      (pwrite_i),
        .paddr_i       (paddr_i),
        .pwdata_i      (pwdata_i),
        .pready_o      (pready_o),
        .prdata_o      (prdata_o),
        .pslverr_o     (pslverr_o),
        .pause_req_i   (pause_req_i),
        .pause_ack_o   (pause_ack_o),
        .pad_i_i       (pad_i_i),
        .pad_o_o       (pad_o_o),
        .pad_mode_o_o  (pad_mode_o_o),
        .pad_otype_o_o (pad_otype_o_o),
        .pin_func_o    (pin_func_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic adam_periph_pkg::paddr_t reg_addr(
        input adam_periph_pkg::blk_sel_t blk,
        input logic [`ADAM_REG_OFS_W-1:0] ofs
    );
        return {2'b00, blk, 2'b00, ofs};
    endfunction

    // Expected pad controls for each pin function
    function automatic void select_pads(
        input  logic [15:0] g_o,
        input  logic [15:0] g_mode,
        input  logic [15:0] g_otype,
        input  logic [31:0] func,
        input  logic        pwm,
        output logic [15:0] o,
        output logic [15:0] mode,
        output logic [15:0] otype
    );
        for (int n = 0; n < 16; n++) begin
            case (adam_periph_pkg::func_t'(func[2*n +: 2]))
                adam_periph_pkg::FUNC_GPIO: begin
                    o[n]     = g_o[n];
                    mode[n]  = g_mode[n];
                    otype[n] = g_otype[n];
                end
                adam_periph_pkg::FUNC_PWM: begin
                    o[n]     = pwm;
                    mode[n]  = 1'b1;
                    otype[n] = 1'b0;
                end
                default: begin
                    o[n]     = 1'b0;
                    mode[n]  = 1'b0;
                    otype[n] = 1'b0;
                end
            endcase
        end
    endfunction

    task automatic add_xfer(
        input op_t                            op,
        input adam_periph_pkg::blk_sel_t      blk,
        input logic [`ADAM_REG_OFS_W-1:0]     ofs,
        input adam_periph_pkg::data_t         wdata,
        input adam_periph_pkg::data_t         exp_data,
        input logic                           exp_err
    );
        step_t s;
        s.op        = op;
        s.addr      = reg_addr(blk, ofs);
        s.wdata     = wdata;
        s.pad_in    = cur_pad;
        s.pause     = cur_pause;
        s.exp_data  = exp_data;
        s.exp_err   = exp_err;
        s.exp_o     = 16'h0;
        s.exp_mode  = 16'h0;
        s.exp_otype = 16'h0;
        s.exp_func  = 32'h0;
        steps.push_back(s);
    endtask

    task automatic add_pads(
        input logic [15:0] g_o,
        input logic [15:0] g_mode,
        input logic [15:0] g_otype,
        input logic [31:0] func,
        input logic        pwm
    );
        step_t s;
        s.op       = OP_PADS;
        s.addr     = '0;
        s.wdata    = '0;
        s.pad_in   = cur_pad;
        s.pause    = cur_pause;
        s.exp_data = '0;
        s.exp_err  = 1'b0;
        s.exp_func = func;
        select_pads(g_o, g_mode, g_otype, func, pwm, s.exp_o, s.exp_mode, s.exp_otype);
        steps.push_back(s);
    endtask

    task automatic build_table();
        cur_pad   = 16'h0;
        cur_pause = 1'b0;
        // Everything reads 0 after reset
        add_pads(16'h0, 16'h0, 16'h0, 32'h0, 1'b0);
        add_xfer(OP_RD, GPIO, `GPIO_OUT, 32'h0, 32'h0, 1'b0);
        add_xfer(OP_RD, GPIO, `GPIO_MODE, 32'h0, 32'h0, 1'b0);
        add_xfer(OP_RD, GPIO, `GPIO_OTYPE, 32'h0, 32'h0, 1'b0);
        add_xfer(OP_RD, GPIO, `GPIO_IN, 32'h0, 32'h0, 1'b0);
        add_xfer(OP_RD, MUX, `MUX_FUNC, 32'h0, 32'h0, 1'b0);
        add_xfer(OP_RD, TMR, `TMR_CTRL, 32'h0, 32'h0, 1'b0);
        add_xfer(OP_RD, TMR, `TMR_PERIOD, 32'h0, 32'h0, 1'b0);
        add_xfer(OP_RD, TMR, `TMR_COMPARE, 32'h0, 32'h0, 1'b0);
        add_xfer(OP_RD, TMR, `TMR_COUNT, 32'h0, 32'h0, 1'b0);
        // Readback
        add_xfer(OP_WR, GPIO, `GPIO_OUT, 32'h0000_A5C3, 32'h0, 1'b0);
        add_xfer(OP_RD, GPIO, `GPIO_OUT, 32'h0, 32'h0000_A5C3, 1'b0);
        add_xfer(OP_WR, GPIO, `GPIO_MODE, 32'h0000_0FF0, 32'h0, 1'b0);
        add_xfer(OP_RD, GPIO, `GPIO_MODE, 32'h0, 32'h0000_0FF0, 1'b0);
        add_xfer(OP_WR, GPIO, `GPIO_OTYPE, 32'h0000_3C3C, 32'h0, 1'b0);
        add_xfer(OP_RD, GPIO, `GPIO_OTYPE, 32'h0, 32'h0000_3C3C, 1'b0);
        // Pins cycle through GPIO, PWM, OFF, OFF2
        add_xfer(OP_WR, MUX, `MUX_FUNC, 32'hE4E4_E4E4, 32'h0, 1'b0);
        add_xfer(OP_RD, MUX, `MUX_FUNC, 32'h0, 32'hE4E4_E4E4, 1'b0);
        add_xfer(OP_WR, TMR, `TMR_PERIOD, 32'h6, 32'h0, 1'b0);
        add_xfer(OP_RD, TMR, `TMR_PERIOD, 32'h0, 32'h6, 1'b0);
        add_xfer(OP_WR, TMR, `TMR_COMPARE, 32'h0, 32'h0, 1'b0);
        add_xfer(OP_RD, TMR, `TMR_COMPARE, 32'h0, 32'h0, 1'b0);
        add_xfer(OP_WR, TMR, `TMR_CTRL, 32'h1, 32'h0, 1'b0);
        add_xfer(OP_RD, TMR, `TMR_CTRL, 32'h0, 32'h1, 1'b0);
        add_pads(16'hA5C3, 16'h0FF0, 16'h3C3C, 32'hE4E4_E4E4, 1'b0);
        // Compare above period keeps pwm high
        add_xfer(OP_WR, TMR, `TMR_COMPARE, 32'h9, 32'h0, 1'b0);
        add_xfer(OP_RD, TMR, `TMR_COMPARE, 32'h0, 32'h9, 1'b0);
        add_pads(16'hA5C3, 16'h0FF0, 16'h3C3C, 32'hE4E4_E4E4, 1'b1);
        // Error responses
        add_xfer(OP_RD, NONE, 6'h00, 32'h0, 32'h0, 1'b1);
        add_xfer(OP_WR, NONE, 6'h04, 32'hFFFF_FFFF, 32'h0, 1'b1);
        add_xfer(OP_RD, GPIO, `GPIO_MODE, 32'h0, 32'h0000_0FF0, 1'b0);
        add_xfer(OP_WR, GPIO, `GPIO_IN, 32'h0000_FFFF, 32'h0, 1'b1);
        add_xfer(OP_RD, GPIO, `GPIO_OUT, 32'h0, 32'h0000_A5C3, 1'b0);
        add_xfer(OP_WR, TMR, `TMR_COUNT, 32'h0000_0003, 32'h0, 1'b1);
        add_xfer(OP_WR, MUX, 6'h04, 32'h0, 32'h0, 1'b1);
        add_xfer(OP_RD, MUX, `MUX_FUNC, 32'h0, 32'hE4E4_E4E4, 1'b0);
        for (int k = 0; k < 4; k++) begin
            cur_pad = 16'($random(seed));
            add_xfer(OP_RD, GPIO, `GPIO_IN, 32'h0, adam_periph_pkg::data_t'(cur_pad), 1'b0);
        end
        // Pause freezes the count and blocks writes
        cur_pause = 1'b1;
        add_xfer(OP_SNAP, TMR, `TMR_COUNT, 32'h0, 32'h0, 1'b0);
        add_xfer(OP_SAME, TMR, `TMR_COUNT, 32'h0, 32'h0, 1'b0);
        add_xfer(OP_WR, GPIO, `GPIO_OUT, 32'h0000_1234, 32'h0, 1'b1);
        add_xfer(OP_RD, GPIO, `GPIO_OUT, 32'h0, 32'h0000_A5C3, 1'b0);
        cur_pause = 1'b0;
        add_xfer(OP_WR, GPIO, `GPIO_OUT, 32'h0000_1234, 32'h0, 1'b0);
        add_xfer(OP_RD, GPIO, `GPIO_OUT, 32'h0, 32'h0000_1234, 1'b0);
    endtask

    task automatic check_data(
        input string                  tag,
        input adam_periph_pkg::data_t got,
        input adam_periph_pkg::data_t exp
    );
        if (got !== exp) begin
            fail_count = fail_count + 1;
            $display("MISMATCH at %0t: %s read 0x%08h, expected 0x%08h", $time, tag, got, exp);
        end else begin
            pass_count = pass_count + 1;
            $display("%s data 0x%08h ok", tag, got);
        end
    endtask

    task automatic check_err(input string tag, input logic got, input logic exp);
        if (got !== exp) begin
            fail_count = fail_count + 1;
            $display("MISMATCH at %0t: %s error flag %b, expected %b", $time, tag, got, exp);
        end else begin
            pass_count = pass_count + 1;
            $display("%s error flag %b ok", tag, got);
        end
    endtask

    task automatic check_pads(
        input string       tag,
        input logic [15:0] o,
        input logic [15:0] mode,
        input logic [15:0] otype,
        input logic [31:0] func,
        input step_t       s
    );
        if (o !== s.exp_o || mode !== s.exp_mode || otype !== s.exp_otype
                || func !== s.exp_func) begin
            fail_count = fail_count + 1;
            $display("MISMATCH at %0t: %s pads o/mode/otype/func %h/%h/%h/%h, expected %h/%h/%h/%h",
                     $time, tag, o, mode, otype, func,
                     s.exp_o, s.exp_mode, s.exp_otype, s.exp_func);
        end else begin
            pass_count = pass_count + 1;
            $display("%s pads %h/%h/%h/%h ok", tag, o, mode, otype, func);
        end
    endtask

    task automatic apb_xfer(
        input  logic                    write,
        input  adam_periph_pkg::paddr_t addr,
        input  adam_periph_pkg::data_t  wdata,
        output adam_periph_pkg::data_t  rdata,
        output logic                    err
    );
        @(posedge clk);
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        pwrite_i  <= write;
        paddr_i   <= addr;
        pwdata_i  <= wdata;
        @(posedge clk);
        penable_i <= 1'b1;
        @(negedge clk);
        if (pready_o !== 1'b1) begin
            fail_count = fail_count + 1;
            $display("At %0t pready_o was not raised in the access cycle", $time);
        end
        rdata = prdata_o;
        err   = pslverr_o;
        @(posedge clk);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
        pwrite_i  <= 1'b0;
    endtask

    task automatic run_step(input step_t s, input int idx);
        adam_periph_pkg::data_t rdata;
        logic                   err;
        string                  tag;
        tag = $sformatf("step %0d", idx);
        @(posedge clk);
        pad_i_i     <= s.pad_in;
        pause_req_i <= s.pause;
        @(negedge clk);
        while (pause_ack_o !== s.pause) @(negedge clk);
        // Lets a new pad value through the synchronizer
        repeat (2) @(posedge clk);
        if (s.op == OP_PADS) begin
            @(negedge clk);
            check_pads(tag, pad_o_o, pad_mode_o_o, pad_otype_o_o, pin_func_o, s);
        end else begin
            apb_xfer(s.op == OP_WR, s.addr, s.wdata, rdata, err);
            check_err(tag, err, s.exp_err);
            if (s.op == OP_RD) begin
                check_data(tag, rdata, s.exp_data);
            end else if (s.op == OP_SNAP) begin
                snap = rdata;
            end else if (s.op == OP_SAME) begin
                check_data(tag, rdata, snap);
            end
        end
    endtask

    initial begin : watchdog
        cycles = 0;
        do begin
            @(posedge clk);
            cycles = cycles + 1;
        end while (cycles < limit);
        $display("Timed out after %0d cycles before the step table finished", cycles);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        rst_i       = 1'b1;
        psel_i      = 1'b0;
        penable_i   = 1'b0;
        pwrite_i    = 1'b0;
        paddr_i     = '0;
        pwdata_i    = '0;
        pause_req_i = 1'b0;
        pad_i_i     = '0;
        pass_count  = 0;
        fail_count  = 0;
        snap        = '0;
        seed        = 4766;
        build_table();
        limit = 16 + 8 * steps.size() + 200;
        repeat (16) @(posedge clk);
        rst_i <= 1'b0;
        @(negedge clk);
        check_err("after reset pause_ack_o", pause_ack_o, 1'b0);
        check_err("after reset pready_o", pready_o, 1'b0);
        check_err("after reset pslverr_o", pslverr_o, 1'b0);
        for (int i = 0; i < steps.size(); i++) begin
            run_step(steps[i], i);
        end
        $display("Checks done: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
